// File: common/wfd_pkg.sv
// wfd readout package holding the data path widths, DAQ word types and DAQ word tags
package wfd_pkg;

    // fill number handed from the trigger manager to the event builder
    typedef logic [23:0] fill_num_t;

    // one word of channel data as it leaves a channel FIFO
    typedef logic [31:0] sample_t;

    // channel index as carried in bits 39:32 of a DAQ data word
    typedef logic [7:0] chan_id_t;

    // payload word count reported in the trailer, bits 47:32
    typedef logic [15:0] word_cnt_t;

    // one word on the DAQ link port
    typedef logic [63:0] daq_word_t;

    // tags in bits 63:56, data words carry zero there
    localparam logic [7:0] header_tag  = 8'ha5;  // first word of each event
    localparam logic [7:0] trailer_tag = 8'h5a;  // closing word of each event

    // fill numbers in flight between trigger manager and event builder
    // 4 is plenty since the trigger manager stalls on busy anyway
    localparam int fifo_depth_default = 4;

endpackage

// File: logic/trigger_manager.sv
// trigger manager that accepts triggers, numbers fills, sends go to the channels and waits on done
`timescale 1ns/1ps

module trigger_manager #(
    parameter int num_chan = 2                 // number of channel FPGAs served
) (
    input  logic                clk125,
    input  logic                rst,
    input  logic                trigger,       // level trigger, sampled every cycle
    input  logic                busy,          // event builder still framing a fill
    output logic [num_chan-1:0] acq_trigs,     // one cycle go pulse to every channel
    output logic                fill_valid,    // fill number waiting for the FIFO
    output wfd_pkg::fill_num_t  fill_num,      // current fill number starting at 1
    input  logic [num_chan-1:0] acq_dones,     // done pulses back from the channels
    input  logic                fill_ready     // FIFO has room
);

    typedef enum logic [1:0] {
        idle,       // ready for the next trigger
        wait_done,  // go sent, collecting done from every channel
        push        // offer the fill number to the FIFO
    } tm_state_t;

    tm_state_t           state;
    logic                accept;     // trigger taken this cycle
    logic [num_chan-1:0] done_seen;  // latched done pulses since go
    logic [num_chan-1:0] done_now;   // latches plus this cycle's pulses

    // triggers outside idle or while the builder is busy fall on the floor
    assign accept     = (state == idle) && trigger && !busy;
    assign done_now   = done_seen | acq_dones;
    assign fill_valid = (state == push);

    always_ff @(posedge clk125) begin
        if (rst) begin
            state     <= idle;
            acq_trigs <= '0;
            done_seen <= '0;
            fill_num  <= '0;                       // first accepted trigger becomes fill 1
        end else begin
            acq_trigs <= {num_chan{accept}};       // go lands on the cycle after acceptance
            case (state)
                idle: begin
                    if (accept) begin
                        fill_num  <= fill_num + 1'b1;  // only accepted triggers use a number
                        done_seen <= '0;
                        state     <= wait_done;
                    end
                end
                wait_done: begin
                    done_seen <= done_now;         // dones are short pulses so keep them
                    if (&done_now)
                        state <= push;             // fill_valid rises next cycle
                end
                push: begin
                    if (fill_ready)
                        state <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // go only on the first cycle of a fresh wait, straight out of idle
    assert property (@(posedge clk125) disable iff (rst)
        (|acq_trigs) |-> (state == wait_done) && (done_seen == '0) && ($past(state) == idle))
    else $error("trigger_manager: go pulse outside the cycle after acceptance");

    // the offered fill number holds until the FIFO takes it
    assert property (@(posedge clk125) disable iff (rst)
        (fill_valid && !fill_ready) |=> (fill_valid && $stable(fill_num)))
    else $error("trigger_manager: fill number dropped or changed while waiting");

endmodule

// File: logic/fill_num_fifo.sv
// fill number FIFO, a small synchronous circular buffer from trigger manager to event builder
`timescale 1ns/1ps

module fill_num_fifo #(
    parameter int fifo_depth = wfd_pkg::fifo_depth_default
) (
    input  logic               clk125,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,   // low when full
    input  wfd_pkg::fill_num_t in_data,
    output logic               out_valid,
    input  logic               out_ready,
    output wfd_pkg::fill_num_t out_data
);
    import wfd_pkg::*;

    localparam int ptr_w = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
    localparam int cnt_w = $clog2(fifo_depth + 1);  // must hold fifo_depth itself

    fill_num_t        mem [fifo_depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;     // words stored
    logic             wr_en;
    logic             rd_en;

    assign in_ready  = (count < cnt_w'(fifo_depth));
    assign out_valid = (count != '0);         // registered count, so one cycle write to read
    assign out_data  = mem[rd_ptr];
    assign wr_en     = in_valid && in_ready;
    assign rd_en     = out_valid && out_ready;

    always_ff @(posedge clk125) begin
        if (wr_en)
            mem[wr_ptr] <= in_data;
    end

    always_ff @(posedge clk125) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= (wr_ptr == ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= (rd_ptr == ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither, level unchanged
            endcase
        end
    end

    // occupancy stays inside the buffer
    assert property (@(posedge clk125) disable iff (rst)
        count <= cnt_w'(fifo_depth))
    else $error("fill_num_fifo: count beyond depth");

endmodule

// File: readout/rx_switch.sv
// rx switch, round robin merge of the channel streams into one stream, packet by packet
`timescale 1ns/1ps

module rx_switch #(
    parameter int num_chan = 2
) (
    input  logic                                          clk125,
    input  logic                                          rst,
    input  logic [num_chan-1:0]                           s_valid,
    input  logic [num_chan-1:0]                           s_last,
    input  logic [num_chan*$bits(wfd_pkg::sample_t)-1:0]  s_data,  // channel 0 in low word
    output logic [num_chan-1:0]                           s_ready,
    output logic                                          m_valid,
    output logic                                          m_last,
    output wfd_pkg::sample_t                              m_data,
    output wfd_pkg::chan_id_t                             m_chan,  // granted channel
    input  logic                                          m_ready
);
    import wfd_pkg::*;

    localparam int idx_w    = (num_chan > 1) ? $clog2(num_chan) : 1;
    localparam int sample_w = $bits(sample_t);

    logic             locked;     // packet in progress, grant frozen
    logic [idx_w-1:0] cur_chan;   // channel owning the locked packet
    logic [idx_w-1:0] last_chan;  // most recent grant, search starts after it
    logic [idx_w-1:0] pick;       // search result when not locked
    logic             found;
    logic [idx_w-1:0] sel;

    // round robin search, starting one past the last grant
    always_comb begin
        int cand;
        found = 1'b0;
        pick  = last_chan;
        for (int i = 1; i <= num_chan; i++) begin
            cand = (int'(last_chan) + i) % num_chan;
            if (!found && s_valid[cand]) begin
                found = 1'b1;
                pick  = idx_w'(cand);
            end
        end
    end

    assign sel     = locked ? cur_chan : pick;
    assign m_valid = locked ? s_valid[cur_chan] : found;
    assign m_last  = s_last[sel];
    assign m_data  = s_data[sel*sample_w +: sample_w];  // straight through, no added cycle
    assign m_chan  = chan_id_t'(sel);

    always_comb begin
        s_ready = '0;
        if (m_ready && (locked || found))
            s_ready[sel] = 1'b1;    // ready only to the granted channel
    end

    always_ff @(posedge clk125) begin
        if (rst) begin
            locked    <= 1'b0;
            cur_chan  <= '0;
            last_chan <= idx_w'(num_chan - 1);  // so the first search begins at channel 0
        end else begin
            if (!locked && found) begin
                cur_chan  <= pick;              // lock even when stalled, keeps m_data steady
                last_chan <= pick;
            end
            if (m_valid && m_ready && m_last)
                locked <= 1'b0;                 // packet done, rearbitrate
            else if (!locked && found)
                locked <= 1'b1;
        end
    end

    // grant may only move once the last word of a packet has gone
    assert property (@(posedge clk125) disable iff (rst)
        (m_valid && !(m_ready && m_last)) |=> $stable(m_chan))
    else $error("rx_switch: grant changed inside a packet");

endmodule

// File: readout/event_builder.sv
// event builder that frames each fill as a DAQ event of header, channel words and trailer
`timescale 1ns/1ps

module event_builder #(
    parameter int num_chan = 2
) (
    input  logic               clk125,
    input  logic               rst,
    input  logic               fifo_valid,
    input  wfd_pkg::fill_num_t fifo_data,
    output logic               fifo_ready,
    input  logic               m_valid,    // merged stream from the rx switch
    input  logic               m_last,
    input  wfd_pkg::sample_t   m_data,
    input  wfd_pkg::chan_id_t  m_chan,
    output logic               m_ready,
    output logic               daq_valid,  // DAQ link port
    output logic               daq_header,
    output logic               daq_trailer,
    output wfd_pkg::daq_word_t daq_data,
    output logic               busy,       // back to the trigger manager
    input  logic               daq_ready
);
    import wfd_pkg::*;

    localparam int pkt_w = $clog2(num_chan + 1);

    typedef enum logic [1:0] {
        idle,     // waiting on a fill number
        header,   // header word on the link
        payload,  // forwarding channel packets
        trailer   // trailer word on the link
    } eb_state_t;

    eb_state_t        state;
    fill_num_t        fill_reg;   // fill being framed
    logic [pkt_w-1:0] pkt_cnt;    // channel packets ended so far
    word_cnt_t        word_cnt;   // payload words sent
    logic             m_xfer;
    logic             daq_xfer;
    logic             last_pkt;   // the packet in flight closes the event

    assign fifo_ready = (state == idle);   // pop only between events
    assign busy       = (state != idle);   // rises the cycle after the pop
    assign m_ready    = (state == payload) && daq_ready;  // link stall reaches the channels
    assign m_xfer     = m_valid && m_ready;
    assign daq_xfer   = daq_valid && daq_ready;
    assign last_pkt   = (pkt_cnt == pkt_w'(num_chan - 1));

    // output word mux whose words hold steady while the link stalls
    always_comb begin
        daq_valid   = 1'b0;
        daq_header  = 1'b0;
        daq_trailer = 1'b0;
        daq_data    = '0;
        case (state)
            header: begin
                daq_valid  = 1'b1;
                daq_header = 1'b1;
                daq_data   = {header_tag, 32'h0, fill_reg};
            end
            payload: begin
                daq_valid = m_valid;
                daq_data  = {24'h0, m_chan, m_data};   // channel id in 39:32
            end
            trailer: begin
                daq_valid   = 1'b1;
                daq_trailer = 1'b1;
                daq_data    = {trailer_tag, 8'h0, word_cnt, 8'h0, fill_reg};
            end
            default: daq_valid = 1'b0;
        endcase
    end

    always_ff @(posedge clk125) begin
        if (fifo_valid && fifo_ready)
            fill_reg <= fifo_data;
    end

    always_ff @(posedge clk125) begin
        if (rst) begin
            state    <= idle;
            pkt_cnt  <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (fifo_valid) begin
                        pkt_cnt  <= '0;
                        word_cnt <= '0;
                        state    <= header;
                    end
                end
                header: begin
                    if (daq_xfer)
                        state <= payload;
                end
                payload: begin
                    if (m_xfer) begin
                        word_cnt <= word_cnt + 1'b1;
                        if (m_last) begin
                            pkt_cnt <= pkt_cnt + 1'b1;
                            if (last_pkt)
                                state <= trailer;   // every channel has ended its packet
                        end
                    end
                end
                trailer: begin
                    if (daq_xfer)
                        state <= idle;              // busy drops next cycle
                end
                default: state <= idle;
            endcase
        end
    end

    // framing flags are exclusive and a trailer only follows the last channel packet
    assert property (@(posedge clk125) disable iff (rst)
        !(daq_header && daq_trailer) && (!daq_trailer || pkt_cnt == pkt_w'(num_chan)))
    else $error("event_builder: header and trailer together or trailer too early");

    // a stalled word stays on the link along with channel data held upstream
    assert property (@(posedge clk125) disable iff (rst)
        (daq_valid && !daq_ready) |=> (daq_valid && $stable(daq_data)))
    else $error("event_builder: DAQ word changed during stall");

endmodule

// File: logic/wfd_top.sv
// wfd readout top, trigger manager, fill FIFO, rx switch and event builder on clk125
`timescale 1ns/1ps

module wfd_top #(
    parameter int num_chan = 2
) (
    input  logic                                         clk125,
    input  logic                                         rst,
    input  logic                                         trigger,
    output logic [num_chan-1:0]                          acq_trigs,   // go to channels
    input  logic [num_chan-1:0]                          acq_dones,   // done from channels
    input  logic [num_chan-1:0]                          chan_valid,
    output logic [num_chan-1:0]                          chan_ready,
    input  logic [num_chan-1:0]                          chan_last,
    input  logic [num_chan*$bits(wfd_pkg::sample_t)-1:0] chan_data,
    output logic                                         daq_valid,
    input  logic                                         daq_ready,
    output logic                                         daq_header,
    output logic                                         daq_trailer,
    output wfd_pkg::daq_word_t                           daq_data,
    output logic                                         busy
);
    import wfd_pkg::*;

    // trigger manager to fill FIFO
    logic      fill_valid;
    logic      fill_ready;
    fill_num_t fill_num;

    // fill FIFO to event builder
    logic      fifo_valid;
    logic      fifo_ready;
    fill_num_t fifo_data;

    // merged channel stream into the event builder
    logic      m_valid;
    logic      m_ready;
    logic      m_last;
    sample_t   m_data;
    chan_id_t  m_chan;

    trigger_manager #(.num_chan(num_chan)) tm (
        .clk125(clk125), .rst(rst),
        .trigger(trigger), .busy(busy),
        .acq_trigs(acq_trigs),
        .fill_valid(fill_valid), .fill_num(fill_num),
        .acq_dones(acq_dones), .fill_ready(fill_ready)
    );

    fill_num_fifo #(.fifo_depth(fifo_depth_default)) fill_fifo (
        .clk125(clk125), .rst(rst),
        .in_valid(fill_valid), .in_ready(fill_ready), .in_data(fill_num),
        .out_valid(fifo_valid), .out_ready(fifo_ready), .out_data(fifo_data)
    );

    rx_switch #(.num_chan(num_chan)) rx_sw (
        .clk125(clk125), .rst(rst),
        .s_valid(chan_valid), .s_last(chan_last), .s_data(chan_data), .s_ready(chan_ready),
        .m_valid(m_valid), .m_last(m_last), .m_data(m_data), .m_chan(m_chan),
        .m_ready(m_ready)
    );

    event_builder #(.num_chan(num_chan)) eb (
        .clk125(clk125), .rst(rst),
        .fifo_valid(fifo_valid), .fifo_data(fifo_data), .fifo_ready(fifo_ready),
        .m_valid(m_valid), .m_last(m_last), .m_data(m_data), .m_chan(m_chan),
        .m_ready(m_ready),
        .daq_valid(daq_valid), .daq_header(daq_header), .daq_trailer(daq_trailer),
        .daq_data(daq_data), .busy(busy), .daq_ready(daq_ready)
    );

endmodule

// File: verification/tb_clock_gen.sv
// testbench clock and reset source, 20 ns clock with reset held for the first 5 cycles
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;   // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        @(negedge clk);            // release away from the sampling edge
        rst = 1'b0;
    end

endmodule

// File: verification/wfd_checker.sv
// DAQ checker that compares each event on the link with its fill number and the channel words
`timescale 1ns/1ps

module wfd_checker #(
    parameter int num_chan = 2
) (
    input  logic                   clk125,
    input  logic                   rst,
    input  logic                   trigger,
    input  logic [num_chan-1:0]    acq_trigs,
    input  logic [num_chan-1:0]    chan_valid,
    input  logic [num_chan-1:0]    chan_ready,
    input  logic [num_chan*32-1:0] chan_data,
    input  logic                   daq_valid,
    input  logic                   daq_ready,
    input  logic                   daq_header,
    input  logic                   daq_trailer,
    input  wfd_pkg::daq_word_t     daq_data,
    input  logic                   busy,
    input  int                     exp_count,   // payload words of the running event
    input  int                     num_events,
    output int                     errors,
    output logic                   done         // closing line printed
);
    import wfd_pkg::*;

    sample_t   sent_q [num_chan][$];  // taken from each channel and not yet seen on the link
    int        ev = 0;                // events closed by a trailer
    int        ev_errs = 0;
    int        failed = 0;
    int        goes = 0;              // go cycles seen so far
    int        words = 0;
    int        cur_chan = 0;          // channel order inside an event only moves up
    logic      trig_seen = 1'b0;
    logic      go_prev = 1'b0;
    logic      stall_prev = 1'b0;
    daq_word_t word_prev;

    task automatic report_fault(input string msg);
        $display("event %0d: %s", ev + 1, msg);
        errors++;
        ev_errs++;
    endtask

    task automatic compare_word(input string what, input daq_word_t exp_w);
        if (daq_data != exp_w) begin
            $display("Error: event %0d %s expected %h actual %h", ev + 1, what, exp_w, daq_data);
            errors++;
            ev_errs++;
        end
    endtask

    always @(posedge clk125) begin
        int c;
        if (rst) begin
            errors = 0;
            done   = 1'b0;
        end else begin
            // quiet link until the first trigger
            if (!trig_seen && (|acq_trigs || daq_valid || busy))
                report_fault("go, daq_valid or busy rose before any trigger");
            trig_seen = trig_seen || trigger;
            if (|acq_trigs && (acq_trigs != '1 || go_prev))
                report_fault("go pulse not on every channel or longer than one cycle");
            if (|acq_trigs)
                goes++;
            go_prev = |acq_trigs;
            for (int k = 0; k < num_chan; k++)
                if (chan_valid[k] && chan_ready[k])
                    sent_q[k].push_back(chan_data[k*32 +: 32]);  // order sent per channel
            if (stall_prev && (!daq_valid || daq_data != word_prev))
                report_fault("DAQ word dropped or changed while daq_ready was low");
            stall_prev = daq_valid && !daq_ready;
            word_prev  = daq_data;
            if (daq_valid && daq_ready && daq_header) begin
                if (goes != ev + 1)
                    report_fault("go pulses do not match the accepted triggers");
                compare_word("header", {header_tag, 32'h0, fill_num_t'(ev + 1)});  // fills from 1
                words    = 0;
                cur_chan = 0;
            end else if (daq_valid && daq_ready && daq_trailer) begin
                compare_word("trailer", {trailer_tag, 8'h0, word_cnt_t'(exp_count), 8'h0,
                                         fill_num_t'(ev + 1)});
                if (words != exp_count)
                    report_fault("payload words on the link differ from the table");
                for (int k = 0; k < num_chan; k++)
                    if (sent_q[k].size() != 0)
                        report_fault("channel words missing from the event");
                if (ev_errs != 0)
                    failed++;
                $display("event %0d fill %0d: %0d words, %s", ev + 1, ev + 1, words,
                         (ev_errs == 0) ? "ok" : "failed");
                ev++;
                ev_errs = 0;
            end else if (daq_valid && daq_ready) begin
                c = -1;
                for (int k = num_chan - 1; k >= 0; k--)
                    if (sent_q[k].size() != 0)
                        c = k;                    // lowest channel with a word waiting
                if (c < cur_chan) begin
                    report_fault("data word with no channel word behind it or out of order");
                end else begin
                    compare_word("data", {24'h0, chan_id_t'(c), sent_q[c].pop_front()});
                    cur_chan = c;
                end
                words++;
            end
            if (ev == num_events && !done) begin
                $display("%0d events checked, %0d passed, %0d failed, %0d errors",
                         ev, ev - failed, failed, errors);
                done = 1'b1;
            end
        end
    end

endmodule

// File: verification/wfd_tb.sv
// wfd readout testbench top, event table, channel models, link back-pressure and timeout
`timescale 1ns/1ps

module wfd_tb;
    localparam int num_chan = 2;
    localparam int num_rows = 6;
    localparam logic [31:0] seed = 32'd50584;

    // per row: words on channel 0, words on channel 1, extra trigger while go is outstanding
    int evt_table [num_rows][3] = '{
        '{1, 1, 0}, '{3, 2, 1}, '{6, 4, 0}, '{2, 6, 1}, '{5, 5, 0}, '{4, 1, 1}
    };

    logic                   clk;
    logic                   rst;
    logic                   trigger;
    logic [num_chan-1:0]    acq_trigs;
    logic [num_chan-1:0]    acq_dones;
    logic [num_chan-1:0]    chan_valid;
    logic [num_chan-1:0]    chan_ready;
    logic [num_chan-1:0]    chan_last;
    logic [num_chan*32-1:0] chan_data;
    logic                   daq_valid;
    logic                   daq_ready = 1'b0;
    logic                   daq_header;
    logic                   daq_trailer;
    wfd_pkg::daq_word_t     daq_data;
    logic                   busy;
    int                     exp_count;
    int                     errors;
    logic                   done;
    logic [31:0]            data_rng = seed;    // sample source
    logic [31:0]            ready_rng = ~seed;  // back-pressure gets its own stream
    int                     cycles = 0;
    int                     limit = 0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    tb_clock_gen clk_gen (.clk(clk), .rst(rst));

    wfd_top #(.num_chan(num_chan)) wfd_top_inst (
        .clk125(clk), .rst(rst), .trigger(trigger), .acq_trigs(acq_trigs),
        .acq_dones(acq_dones), .chan_valid(chan_valid), .chan_ready(chan_ready),
        .chan_last(chan_last), .chan_data(chan_data), .daq_valid(daq_valid),
        .daq_ready(daq_ready), .daq_header(daq_header), .daq_trailer(daq_trailer),
        .daq_data(daq_data), .busy(busy)
    );

    wfd_checker #(.num_chan(num_chan)) chk (
        .clk125(clk), .rst(rst), .trigger(trigger), .acq_trigs(acq_trigs),
        .chan_valid(chan_valid), .chan_ready(chan_ready), .chan_data(chan_data),
        .daq_valid(daq_valid), .daq_ready(daq_ready), .daq_header(daq_header),
        .daq_trailer(daq_trailer), .daq_data(daq_data), .busy(busy),
        .exp_count(exp_count), .num_events(num_rows), .errors(errors), .done(done)
    );

    // link ready about three cycles in four
    always @(negedge clk) begin
        ready_rng = xorshift32(ready_rng);
        daq_ready = (ready_rng[3:2] != 2'b00);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("timeout: events still incomplete after %0d cycles", limit);
            $display("Finished with errors");
            $finish;
        end
    end

    // channels report done on different cycles, so the manager has to latch them
    task automatic answer_go();
        for (int c = 0; c < num_chan; c++) begin
            repeat (2) @(negedge clk);
            acq_dones[c] = 1'b1;
            @(negedge clk);
            acq_dones[c] = 1'b0;
        end
    endtask

    // both channels start together, each moves on only when its word was taken
    task automatic send_packets(input int n0, input int n1);
        int                  n [num_chan];
        int                  sent [num_chan] = '{default: 0};
        logic [num_chan-1:0] xfer = '0;
        n[0] = n0;
        n[1] = n1;
        while (sent[0] < n[0] || sent[1] < n[1]) begin
            @(negedge clk);
            for (int c = 0; c < num_chan; c++) begin
                if (xfer[c])
                    sent[c]++;
                if (sent[c] < n[c]) begin
                    if (xfer[c] || !chan_valid[c]) begin
                        data_rng = xorshift32(data_rng);
                        chan_data[c*32 +: 32] = data_rng;  // fresh sample
                    end
                    chan_valid[c] = 1'b1;
                    chan_last[c]  = (sent[c] == n[c] - 1);
                end else begin
                    chan_valid[c] = 1'b0;
                    chan_last[c]  = 1'b0;
                end
            end
            #1;                               // ready settles well before the rising edge
            xfer = chan_valid & chan_ready;   // these transfer on the next rising edge
        end
    endtask

    initial begin
        trigger    = 1'b0;
        acq_dones  = '0;
        chan_valid = '0;
        chan_last  = '0;
        chan_data  = '0;
        exp_count  = 0;
        for (int r = 0; r < num_rows; r++)
            limit += 40 + 4 * (evt_table[r][0] + evt_table[r][1]);
        @(negedge clk);
        while (rst)
            @(negedge clk);
        repeat (3) @(negedge clk);   // idle cycles after reset
        for (int r = 0; r < num_rows; r++) begin
            while (busy)
                @(negedge clk);
            exp_count = evt_table[r][0] + evt_table[r][1];
            trigger   = 1'b1;        // level, held until the go shows up
            do
                @(negedge clk);
            while (!acq_trigs[0]);
            trigger = 1'b0;
            if (evt_table[r][2] != 0) begin
                @(negedge clk);
                trigger = 1'b1;      // manager is waiting on done, should be ignored
                @(negedge clk);
                trigger = 1'b0;
            end
            answer_go();
            send_packets(evt_table[r][0], evt_table[r][1]);
        end
        while (!done)
            @(negedge clk);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// File: compile.f
common/wfd_pkg.sv
logic/trigger_manager.sv
logic/fill_num_fifo.sv
readout/rx_switch.sv
readout/event_builder.sv
logic/wfd_top.sv
verification/tb_clock_gen.sv
verification/wfd_checker.sv
verification/wfd_tb.sv

// File: run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -sv --top-module wfd_tb -f compile.f > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/Vwfd_tb > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0
